/* stoch_integ.f */
+incdir+source
source/stoch_integ_pkg.sv
source/stoch_lfsr.sv
source/sc_updown_counter.sv
source/integrator_chain.sv
source/stoch_apb_regs.sv
source/stoch_integ_top.sv
verif/stoch_integ_sva.sv
verif/stoch_integ_tb.sv

/* Makefile */
# Verilator build and run of the stochastic integrator testbench

TOP = stoch_integ_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --top-module $(TOP) -f stoch_integ.f -o V$(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f stoch_integ.f
	verilator --lint-only --top-module stoch_integ_top \
		+incdir+source source/stoch_integ_pkg.sv source/stoch_lfsr.sv \
		source/sc_updown_counter.sv source/integrator_chain.sv \
		source/stoch_apb_regs.sv source/stoch_integ_top.sv

clean:
	rm -rf obj_dir sim.log

/* verif/stoch_integ_golden.txt */
# Columns: op addr(hex) value(hex) count(dec); count is poll tries or cycles, else 0
# Ops: W write, R read, P poll, E erroring write, I idle, S sample sn_out, T end of test
# Test 1: reset values and input readback
R 00 00000000 0
R 0c 00000000 0
R 10 00000000 0
R 14 00000000 0
W 04 000000a5 0
W 08 00000137 0
R 04 000000a5 0
R 08 00000137 0
T 00 00000001 0
# Test 2: zero inputs never set a comparator bit
W 04 00000000 0
W 08 00000000 0
W 00 00000001 0
R 00 00000001 0
S 00 00000000 100
R 0c 00000000 0
R 10 00000000 0
R 14 00000000 0
T 00 00000002 0
# Test 3: full input a drives the chain into saturation
W 04 000001ff 0
P 0c 000001ff 3000
P 10 000001ff 3000
P 14 000001ff 3000
T 00 00000003 0
# Test 4: hold freezes, then full input b drains every stage
W 00 00000000 0
R 00 00000000 0
R 14 000001ff 0
I 00 00000000 200
R 14 000001ff 0
R 0c 000001ff 0
W 04 00000000 0
W 08 000001ff 0
W 00 00000001 0
P 0c 00000000 3000
P 10 00000000 3000
P 14 00000000 3000
T 00 00000004 0
# Test 5: clear empties counters and snapshots at once
W 08 00000000 0
W 04 000001ff 0
W 00 00000001 0
I 00 00000000 100
W 00 00000002 0
R 00 00000000 0
R 0c 00000000 0
R 10 00000000 0
R 14 00000000 0
T 00 00000005 0
# Test 6: rejected writes leave inputs and mode alone
W 00 00000001 0
E 20 00000000 0
E 10 00000005 0
E 00 00000003 0
E 00 00000102 0
R 04 000001ff 0
R 08 00000000 0
R 00 00000001 0
T 00 00000006 0

/* verif/stoch_integ_tb.sv */
// Testbench for the stochastic integrator, runs the APB operations of the golden file against the DUT
`timescale 1ns/10ps
`include "stoch_integ_macros.svh"

module stoch_integ_tb;

    logic                  clk;
    logic                  rst_n;
    logic [`SI_APB_AW-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [`SI_APB_DW-1:0] pwdata;
    logic [`SI_APB_DW-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  sn_out;

    integer seed;         // Idle gap generator
    integer fd;
    integer op_no;        // Operation counter for messages
    integer test_errs;    // Errors in the running test
    integer total_errs;
    integer n_pass;
    integer n_fail;

    stoch_integ_top u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .sn_out  (sn_out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    // Backstop against a stuck run
    initial begin
        repeat (400000) @(posedge clk);
        $display("Simulation exceeded its cycle limit and was stopped");
        $display("TESTS FAILED");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("Error: %s expected 0x%h, actual 0x%h (operation %0d)", name, exp, act, op_no);
            test_errs  = test_errs + 1;
            total_errs = total_errs + 1;
        end
    endtask

    // One APB transfer after 0 to 3 idle cycles
    task automatic apb_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                                output logic [31:0] rdata, output logic err);
        integer n_idle;
        integer tries;
        n_idle = {$random(seed)} % 4;
        repeat (n_idle) @(posedge clk);
        @(posedge clk);
        psel    <= 1'b1;      // Setup phase
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;      // Access phase
        tries = 0;
        @(negedge clk);
        while (pready !== 1'b1 && tries < 16) begin
            tries = tries + 1;
            @(negedge clk);
        end
        if (pready !== 1'b1) begin
            $display("APB transfer to address 0x%h never completed, pready stayed low", addr);
            test_errs  = test_errs + 1;
            total_errs = total_errs + 1;
        end
        rdata = prdata;       // Stable mid cycle
        err   = pslverr;
        @(posedge clk);       // Transfer completes here
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic run_operation(input logic [7:0] op, input logic [7:0] addr,
                                 input logic [31:0] value, input integer count);
        logic [31:0] rdata;
        logic        err;
        logic        matched;
        integer      tries;
        case (op)
            "W": begin
                apb_transfer(1'b1, addr, value, rdata, err);
                check_value("pslverr", 32'(0), {31'b0, err});
            end
            "R": begin
                apb_transfer(1'b0, addr, 32'(0), rdata, err);
                check_value("pslverr", 32'(0), {31'b0, err});
                check_value("prdata", value, rdata);
            end
            "P": begin
                matched = 1'b0;
                tries   = 0;
                while (!matched && tries < count) begin   // Snapshot latency varies
                    apb_transfer(1'b0, addr, 32'(0), rdata, err);
                    tries = tries + 1;
                    if (rdata === value && err === 1'b0) begin
                        matched = 1'b1;
                    end
                end
                if (!matched) begin
                    $display("Polling address 0x%h gave up after %0d reads without seeing 0x%h",
                             addr, tries, value);
                    test_errs  = test_errs + 1;
                    total_errs = total_errs + 1;
                end
            end
            "E": begin
                apb_transfer(1'b1, addr, value, rdata, err);
                check_value("pslverr", 32'(1), {31'b0, err});   // Must be rejected
            end
            "I": repeat (count) @(posedge clk);
            "S": begin
                for (int i = 0; i < count; i++) begin
                    @(negedge clk);
                    check_value("sn_out", {31'b0, value[0]}, {31'b0, sn_out});
                end
            end
            "T": begin
                if (test_errs == 0) begin
                    n_pass = n_pass + 1;
                    $display("Test %0d passed", value);
                end else begin
                    n_fail = n_fail + 1;
                    $display("Test %0d failed with %0d errors", value, test_errs);
                end
                test_errs = 0;
            end
            default: begin
                $display("Golden file operation %0d has an unknown letter %c", op_no, op);
                test_errs  = test_errs + 1;
                total_errs = total_errs + 1;
            end
        endcase
    endtask

    initial begin
        logic [7:0]         op;
        logic [7:0]         addr;
        logic [31:0]        value;
        integer             count;
        integer             n;
        logic               done;
        logic [8*200-1:0]   rest;   // Remainder of a comment line
        seed       = 70335;
        rst_n      = 1'b1;          // Reset asserted
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        op_no      = 0;
        test_errs  = 0;
        total_errs = 0;
        n_pass     = 0;
        n_fail     = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b0;
        fd = $fopen("verif/stoch_integ_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file verif/stoch_integ_golden.txt");
            total_errs = total_errs + 1;
        end else begin
            done = 1'b0;
            while (!done) begin
                n = $fscanf(fd, " %c", op);
                if (n != 1) begin
                    done = 1'b1;                 // End of file
                end else if (op == "#") begin
                    n = $fgets(rest, fd);        // Skip comment
                end else begin
                    n = $fscanf(fd, "%h %h %d", addr, value, count);
                    op_no = op_no + 1;
                    if (n != 3) begin
                        $display("Golden file operation %0d is malformed", op_no);
                        total_errs = total_errs + 1;
                        done = 1'b1;
                    end else begin
                        run_operation(op, addr, value, count);
                    end
                end
            end
            $fclose(fd);
        end
        $display("Summary: %0d tests passed, %0d tests failed", n_pass, n_fail);
        if (total_errs == 0 && n_fail == 0 && n_pass > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verif/stoch_integ_sva.sv */
// APB protocol and clear behavior assertions, bound onto the integrator top level
`timescale 1ns/10ps

module stoch_integ_sva (
    input logic                    clk,
    input logic                    rst_n,     // Active high
    input logic                    psel,
    input logic                    penable,
    input logic                    pready,
    input logic                    pslverr,
    input logic                    clear,     // Internal clear pulse
    input stoch_integ_pkg::value_t cnt_a,
    input stoch_integ_pkg::value_t cnt_b,
    input stoch_integ_pkg::value_t cnt_c
);

    // Slave error only inside an access phase
    a_err_in_access: assert property (@(posedge clk) disable iff (rst_n)
        pslverr |-> (psel && penable))
        else $error("pslverr raised outside an APB access phase");

    // Zero wait states
    a_ready_on_enable: assert property (@(posedge clk) disable iff (rst_n)
        penable |-> pready)
        else $error("pready low during an APB access phase");

    // All integrators empty one cycle after a clear
    a_clear_zeroes: assert property (@(posedge clk) disable iff (rst_n)
        clear |=> ((cnt_a == '0) && (cnt_b == '0) && (cnt_c == '0)))
        else $error("Counters not zero one cycle after clear");

endmodule

bind stoch_integ_top stoch_integ_sva u_sva (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pready  (pready),
    .pslverr (pslverr),
    .clear   (clear),
    .cnt_a   (cnt_a),
    .cnt_b   (cnt_b),
    .cnt_c   (cnt_c)
);

/* source/stoch_integ_top.sv */
// Top level of the stochastic integrator, an APB slave with the last stage bitstream on a pin
`timescale 1ns/10ps
`include "stoch_integ_macros.svh"

module stoch_integ_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`SI_APB_AW-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [`SI_APB_DW-1:0] pwdata,
    output logic [`SI_APB_DW-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  sn_out
);

    stoch_integ_pkg::value_t in_a;
    stoch_integ_pkg::value_t in_b;
    stoch_integ_pkg::value_t cnt_a;
    stoch_integ_pkg::value_t cnt_b;
    stoch_integ_pkg::value_t cnt_c;
    stoch_integ_pkg::value_t rnd_0;
    stoch_integ_pkg::value_t rnd_1;
    stoch_integ_pkg::value_t rnd_2;
    stoch_integ_pkg::value_t rnd_3;
    stoch_integ_pkg::value_t rnd_4;
    logic                    run;
    logic                    clear;

    // Bus side, inputs and snapshots
    stoch_apb_regs u_regs (
        .clk     (clk),     .rst_n  (rst_n),
        .psel    (psel),    .penable (penable),
        .pwrite  (pwrite),  .paddr  (paddr),
        .pwdata  (pwdata),  .prdata (prdata),
        .pready  (pready),  .pslverr (pslverr),
        .cnt_a   (cnt_a),   .cnt_b  (cnt_b),
        .cnt_c   (cnt_c),   .in_a   (in_a),
        .in_b    (in_b),    .run    (run),
        .clear   (clear)
    );

    // Free running random words
    stoch_lfsr u_lfsr (
        .clk   (clk),   .rst_n (rst_n),
        .rnd_0 (rnd_0), .rnd_1 (rnd_1),
        .rnd_2 (rnd_2), .rnd_3 (rnd_3),
        .rnd_4 (rnd_4)
    );

    // Integrators
    integrator_chain u_chain (
        .clk   (clk),   .rst_n  (rst_n),
        .run   (run),   .clear  (clear),
        .in_a  (in_a),  .in_b   (in_b),
        .rnd_0 (rnd_0), .rnd_1  (rnd_1),
        .rnd_2 (rnd_2), .rnd_3  (rnd_3),
        .rnd_4 (rnd_4), .cnt_a  (cnt_a),
        .cnt_b (cnt_b), .cnt_c  (cnt_c),
        .sn_out (sn_out)
    );

endmodule

/* source/stoch_apb_regs.sv */
// APB register block holding the inputs and run mode, and capturing counter snapshots on a fixed interval
`timescale 1ns/10ps
`include "stoch_integ_macros.svh"

module stoch_apb_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`SI_APB_AW-1:0]   paddr,
    input  logic [`SI_APB_DW-1:0]   pwdata,
    output logic [`SI_APB_DW-1:0]   prdata,
    output logic                    pready,
    output logic                    pslverr,
    input  stoch_integ_pkg::value_t cnt_a,
    input  stoch_integ_pkg::value_t cnt_b,
    input  stoch_integ_pkg::value_t cnt_c,
    output stoch_integ_pkg::value_t in_a,
    output stoch_integ_pkg::value_t in_b,
    output logic                    run,     // Run mode level
    output logic                    clear    // One cycle after a CMD_CLEAR write
);

    localparam int TMR_W = $clog2(`SI_SNAP_INTERVAL);

    stoch_integ_pkg::reg_addr_e addr;
    stoch_integ_pkg::cmd_e      cmd;
    logic                       acc;       // Access phase
    logic                       addr_bad;
    logic                       wr_ro;     // Target is a snapshot
    logic                       cmd_bad;
    logic                       wr_en;     // Accepted write
    logic [TMR_W-1:0]           tmr;
    logic                       tmr_wrap;
    stoch_integ_pkg::value_t    snap_a;
    stoch_integ_pkg::value_t    snap_b;
    stoch_integ_pkg::value_t    snap_c;

    assign addr   = stoch_integ_pkg::reg_addr_e'(paddr);
    assign cmd    = stoch_integ_pkg::cmd_e'(pwdata[1:0]);
    assign acc    = psel & penable;
    assign pready = 1'b1;   // No wait states

    // Address decode
    always_comb begin
        addr_bad = 1'b0;
        wr_ro    = 1'b0;
        case (addr)
            stoch_integ_pkg::REG_CTRL,
            stoch_integ_pkg::REG_IN_A,
            stoch_integ_pkg::REG_IN_B:  wr_ro = 1'b0;
            stoch_integ_pkg::REG_OUT_A,
            stoch_integ_pkg::REG_OUT_B,
            stoch_integ_pkg::REG_OUT_C: wr_ro = 1'b1;
            default:                    addr_bad = 1'b1;
        endcase
    end

    // Only the three defined codes with clean upper bits are accepted
    always_comb begin
        cmd_bad = (pwdata[`SI_APB_DW-1:2] != '0);
        case (cmd)
            stoch_integ_pkg::CMD_HOLD,
            stoch_integ_pkg::CMD_RUN,
            stoch_integ_pkg::CMD_CLEAR: ;
            default:                    cmd_bad = 1'b1;
        endcase
    end

    assign pslverr = acc & (addr_bad |
                            (pwrite & (wr_ro | ((addr == stoch_integ_pkg::REG_CTRL) & cmd_bad))));
    assign wr_en   = acc & pwrite & ~pslverr;   // An erroring write is dropped

    // Inputs, run mode and the clear pulse
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            in_a  <= '0;
            in_b  <= '0;
            run   <= 1'b0;
            clear <= 1'b0;
        end else begin
            clear <= 1'b0;   // Pulse lasts one cycle
            if (wr_en) begin
                case (addr)
                    stoch_integ_pkg::REG_CTRL: begin
                        run   <= (cmd == stoch_integ_pkg::CMD_RUN);    // Hold and clear stop it
                        clear <= (cmd == stoch_integ_pkg::CMD_CLEAR);
                    end
                    stoch_integ_pkg::REG_IN_A: in_a <= pwdata[`SI_VAL_W-1:0];
                    stoch_integ_pkg::REG_IN_B: in_b <= pwdata[`SI_VAL_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    assign tmr_wrap = run & (tmr == TMR_W'(`SI_SNAP_INTERVAL - 1));

    // Interval timer and snapshots advance only while running
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            tmr    <= '0;
            snap_a <= '0;
            snap_b <= '0;
            snap_c <= '0;
        end else if (clear) begin
            tmr    <= '0;   // Same edge that zeroes the counters
            snap_a <= '0;
            snap_b <= '0;
            snap_c <= '0;
        end else if (run) begin
            tmr <= tmr + 1'b1;   // Wraps by itself
            if (tmr_wrap) begin
                snap_a <= cnt_a;
                snap_b <= cnt_b;
                snap_c <= cnt_c;
            end
        end
    end

    // Read mux output stays valid throughout the access phase
    always_comb begin
        prdata = '0;
        case (addr)
            stoch_integ_pkg::REG_CTRL:  prdata[0] = run;
            stoch_integ_pkg::REG_IN_A:  prdata[`SI_VAL_W-1:0] = in_a;
            stoch_integ_pkg::REG_IN_B:  prdata[`SI_VAL_W-1:0] = in_b;
            stoch_integ_pkg::REG_OUT_A: prdata[`SI_VAL_W-1:0] = snap_a;
            stoch_integ_pkg::REG_OUT_B: prdata[`SI_VAL_W-1:0] = snap_b;
            stoch_integ_pkg::REG_OUT_C: prdata[`SI_VAL_W-1:0] = snap_c;
            default:                    prdata = '0;
        endcase
    end

endmodule

/* source/integrator_chain.sv */
// Three chained stochastic integrators with their bitstream generators, approximating t, t^2/2, t^3/6
`timescale 1ns/10ps

module integrator_chain (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    run,
    input  logic                    clear,
    input  stoch_integ_pkg::value_t in_a,    // Integrand probability
    input  stoch_integ_pkg::value_t in_b,    // Decay probability
    input  stoch_integ_pkg::value_t rnd_0,
    input  stoch_integ_pkg::value_t rnd_1,
    input  stoch_integ_pkg::value_t rnd_2,
    input  stoch_integ_pkg::value_t rnd_3,
    input  stoch_integ_pkg::value_t rnd_4,
    output stoch_integ_pkg::value_t cnt_a,
    output stoch_integ_pkg::value_t cnt_b,
    output stoch_integ_pkg::value_t cnt_c,
    output logic                    sn_out   // Bitstream of the last stage
);

    logic bit_in_a;   // Input bitstreams
    logic bit_in_b;
    logic bit_a;      // Counter bitstreams
    logic bit_b;
    logic bit_c;

    // Comparators give a 1 when the value beats the random word
    // A value of 0 never produces a 1
    assign bit_in_a = (in_a > rnd_0);
    assign bit_in_b = (in_b > rnd_1);
    assign bit_a    = (cnt_a > rnd_2);
    assign bit_b    = (cnt_b > rnd_3);
    assign bit_c    = (cnt_c > rnd_4);

    // First stage integrates input a
    sc_updown_counter u_int_a (
        .clk   (clk),
        .rst_n (rst_n),
        .run   (run),
        .clear (clear),
        .inc   (bit_in_a),
        .dec   (bit_in_b),
        .count (cnt_a)
    );

    // Second stage integrates the first
    sc_updown_counter u_int_b (
        .clk   (clk),
        .rst_n (rst_n),
        .run   (run),
        .clear (clear),
        .inc   (bit_a),
        .dec   (bit_in_b),   // Same decay stream on every stage
        .count (cnt_b)
    );

    // Third stage integrates the second
    sc_updown_counter u_int_c (
        .clk   (clk),
        .rst_n (rst_n),
        .run   (run),
        .clear (clear),
        .inc   (bit_b),
        .dec   (bit_in_b),
        .count (cnt_c)
    );

    assign sn_out = bit_c;   // Low while cnt_c is 0

endmodule

/* source/sc_updown_counter.sv */
// Saturating up/down counter that integrates one stochastic bitstream against another
`timescale 1ns/10ps
`include "stoch_integ_macros.svh"

module sc_updown_counter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    run,     // Update enable, a level
    input  logic                    clear,   // Synchronous zero, beats run
    input  logic                    inc,     // Up bitstream
    input  logic                    dec,     // Down bitstream
    output stoch_integ_pkg::value_t count
);

    logic at_max;
    logic at_min;
    logic up;
    logic down;

    assign at_max = (count == stoch_integ_pkg::value_t'(`SI_VAL_MAX));
    assign at_min = (count == '0);

    // Equal bits cancel out
    assign up   = inc & ~dec & ~at_max;  // Stops at the top
    assign down = dec & ~inc & ~at_min;  // Stops at zero

    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;             // Regardless of run
        end else if (run) begin
            if (up) begin
                count <= count + 1'b1;
            end else if (down) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* source/stoch_lfsr.sv */
// Free-running Fibonacci LFSR that feeds five scrambled random words to the bitstream comparators
`timescale 1ns/10ps
`include "stoch_integ_macros.svh"

module stoch_lfsr (
    input  logic                    clk,
    input  logic                    rst_n,
    output stoch_integ_pkg::value_t rnd_0,   // Input a comparator
    output stoch_integ_pkg::value_t rnd_1,   // Input b comparator
    output stoch_integ_pkg::value_t rnd_2,   // Integrator a comparator
    output stoch_integ_pkg::value_t rnd_3,   // Integrator b comparator
    output stoch_integ_pkg::value_t rnd_4    // Integrator c comparator
);

    logic [`SI_LFSR_W-1:0] lfsr;
    logic                  fb;

    assign fb = lfsr[`SI_LFSR_TAP_A] ^ lfsr[`SI_LFSR_TAP_B];  // Maximal length taps

    // Shifts every cycle, also while the chain is held
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            lfsr <= `SI_LFSR_W'(`SI_LFSR_SEED);
        end else begin
            lfsr <= {lfsr[`SI_LFSR_W-2:0], fb};
        end
    end

    // Different bit orders per position keep the bitstreams weakly correlated
    assign rnd_0 = lfsr[8:0];
    assign rnd_1 = {lfsr[5:0], lfsr[18:16]};
    assign rnd_2 = lfsr[30:22];
    assign rnd_3 = {lfsr[15:13], lfsr[6:1]};
    assign rnd_4 = {lfsr[24:19], lfsr[14:12]};

endmodule

/* source/stoch_integ_pkg.sv */
// Value type, command and register address enums, referenced by scoped name from RTL and testbench
`include "stoch_integ_macros.svh"

package stoch_integ_pkg;

    // Probability on the input side, count on the integrator side
    typedef logic [`SI_VAL_W-1:0] value_t;

    // Written to the low bits of REG_CTRL
    typedef enum logic [1:0] {
        CMD_HOLD  = 2'd0,   // Freeze the chain
        CMD_RUN   = 2'd1,   // Integrate every cycle
        CMD_CLEAR = 2'd2    // Zero counters and snapshots, then hold
    } cmd_e;

    // Byte offsets of the APB registers
    typedef enum logic [`SI_APB_AW-1:0] {
        REG_CTRL  = 8'h00,  // Command on write, run mode on read
        REG_IN_A  = 8'h04,  // Input probability a
        REG_IN_B  = 8'h08,  // Input probability b, drives every decrement
        REG_OUT_A = 8'h0C,  // Snapshot of integrator a
        REG_OUT_B = 8'h10,  // Snapshot of integrator b
        REG_OUT_C = 8'h14   // Snapshot of integrator c
    } reg_addr_e;

endpackage

/* source/stoch_integ_macros.svh */
// Width, limit, LFSR, snapshot and APB bus constants, included by the package and RTL files
`ifndef STOCH_INTEG_MACROS_SVH
`define STOCH_INTEG_MACROS_SVH

// Probability and counter values
`define SI_VAL_W 9        // Bits per probability or counter value
`define SI_VAL_MAX 511    // Counter saturates here

// Random source
`define SI_LFSR_W 31          // Register length
`define SI_LFSR_SEED 134995   // Non-zero reset state
`define SI_LFSR_TAP_A 30      // Feedback taps
`define SI_LFSR_TAP_B 27

// Snapshot capture period in running cycles
// Must stay a power of two since the timer wraps on its own
`define SI_SNAP_INTERVAL 16

// APB bus
`define SI_APB_AW 8    // Address width
`define SI_APB_DW 32   // Data width

`endif
